// ==== vlog.f ====
common/imuldiv_op_pkg.sv
common/imuldiv_data_pkg.sv
execute/imuldiv_mul_iter.sv
execute/imuldiv_div_iter.sv
execute/imuldiv_execute.sv
hw/imuldiv_decode.sv
hw/imuldiv_result.sv
hw/imuldiv_top.sv
sim/imuldiv_tb.sv

// ==== sim/imuldiv_tb.sv ====
/*
  directed and random testbench for the mul/div unit: reference model,
  compare tasks, LCG operand source and a watchdog
*/
`timescale 1ns/1ps
`default_nettype none

module imuldiv_tb
  import imuldiv_op_pkg::*;
  import imuldiv_data_pkg::*;
();

  localparam int clk_period = 40;
  localparam int latency    = 34;
  localparam int max_stall  = 7;
  // 98 mul corners, 84 div corners, 14 div by zero, 8 stalled, 200 random
  localparam int n_ops      = 404;
  localparam longint watchdog_ns =
    longint'(n_ops * (latency + max_stall + 4) + 16) * clk_period;

  logic            clk;
  logic            reset;
  logic            req_val;
  logic            req_rdy;
  imuldiv_fn_t     req_fn;
  imuldiv_word_t   req_a;
  imuldiv_word_t   req_b;
  logic            resp_val;
  logic            resp_rdy;
  imuldiv_result_t resp_result;
  logic [31:0]     rng_state;

  imuldiv_top imuldiv_top_inst (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  always #(clk_period / 2) clk = ~clk;

  // ----------------------------
  // reference model and LCG
  // ----------------------------
  function automatic imuldiv_result_t ref_result(imuldiv_fn_t fn, imuldiv_word_t a,
                                                 imuldiv_word_t b);
    imuldiv_result_t r;
    longint          sa;
    longint          sb;
    logic [63:0]     ua;
    logic [63:0]     ub;
    sa     = longint'($signed(a));
    sb     = longint'($signed(b));
    ua     = {32'd0, a};
    ub     = {32'd0, b};
    r.prod = '0;
    if (fn == fn_mul) begin
      r.prod = sa * sb;
    end else if (fn == fn_mulu) begin
      r.prod = ua * ub;
    end else if (b == '0) begin
      // divide by zero for either signedness
      r.qr.quo = '1;
      r.qr.rem = a;
    end else if (fn == fn_div) begin
      // 64-bit math lets min / -1 wrap back to min after truncation
      r.qr.quo = imuldiv_word_t'(sa / sb);
      r.qr.rem = imuldiv_word_t'(sa % sb);
    end else begin
      r.qr.quo = a / b;
      r.qr.rem = a % b;
    end
    return r;
  endfunction

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic imuldiv_word_t corner_value(int i);
    case (i)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'hffff_ffff;
      3:       return 32'h8000_0000;
      4:       return 32'h7fff_ffff;
      5:       return 32'h9abc_def0;
      default: return 32'h0000_000d;
    endcase
  endfunction

  // ----------------------------
  // compare tasks
  // ----------------------------
  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_product(input string name, input imuldiv_result_t exp_r,
                               input imuldiv_result_t act_r);
    if (act_r.prod !== exp_r.prod) begin
      stop_with_error($sformatf("MISMATCH %s: expected %h, actual %h",
                                name, exp_r.prod, act_r.prod));
    end
  endtask

  task automatic check_quo_rem(input string name, input imuldiv_result_t exp_r,
                               input imuldiv_result_t act_r);
    if (act_r.qr.quo !== exp_r.qr.quo || act_r.qr.rem !== exp_r.qr.rem) begin
      stop_with_error($sformatf("MISMATCH %s: expected quo %h rem %h, actual quo %h rem %h",
                                name, exp_r.qr.quo, exp_r.qr.rem,
                                act_r.qr.quo, act_r.qr.rem));
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      stop_with_error($sformatf("MISMATCH %s: expected %b, actual %b", name, exp_v, act_v));
    end
  endtask

  task automatic check_count(input string name, input int exp_v, input int act_v);
    if (act_v != exp_v) begin
      stop_with_error($sformatf("MISMATCH %s: expected %0d, actual %0d", name, exp_v, act_v));
    end
  endtask

  // ----------------------------
  // handshake tasks
  // ----------------------------
  task automatic issue_op(input imuldiv_fn_t fn, input imuldiv_word_t a, input imuldiv_word_t b);
    @(posedge clk);
    req_val <= 1'b1;
    req_fn  <= fn;
    req_a   <= a;
    req_b   <= b;
    @(negedge clk);
    while (!req_rdy) begin
      @(posedge clk);
      @(negedge clk);
    end
    // this edge accepts
    @(posedge clk);
    req_val <= 1'b0;
  endtask

  // counts edges from the accepting edge to resp_val
  task automatic wait_latency(input string name);
    int edges;
    edges = 0;
    @(negedge clk);
    while (!resp_val && edges < 4 * latency) begin
      check_flag({name, " req_rdy busy"}, 1'b0, req_rdy);
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    if (!resp_val) begin
      stop_with_error({name, ": no response from the DUT"});
    end
    check_count({name, " latency"}, latency, edges);
    check_flag({name, " req_rdy pending"}, 1'b0, req_rdy);
  endtask

  task automatic take_resp(input string name, input int stall, output imuldiv_result_t r);
    imuldiv_result_t held;
    held = resp_result;
    repeat (stall) begin
      @(posedge clk);
      @(negedge clk);
      check_flag({name, " resp_val held"}, 1'b1, resp_val);
      check_product({name, " resp_result held"}, held, resp_result);
      check_flag({name, " req_rdy stalled"}, 1'b0, req_rdy);
    end
    @(posedge clk);
    resp_rdy <= 1'b1;
    @(negedge clk);
    check_flag({name, " req_rdy before take"}, 1'b0, req_rdy);
    // taking edge
    @(posedge clk);
    resp_rdy <= 1'b0;
    @(negedge clk);
    check_flag({name, " resp_val cleared"}, 1'b0, resp_val);
    check_flag({name, " req_rdy after take"}, 1'b1, req_rdy);
    r = held;
  endtask

  task automatic run_op(input string tag, input imuldiv_fn_t fn, input imuldiv_word_t a,
                        input imuldiv_word_t b, input int stall);
    imuldiv_result_t expected;
    imuldiv_result_t actual;
    string           name;
    name     = $sformatf("%s fn=%0d a=%h b=%h", tag, fn, a, b);
    expected = ref_result(fn, a, b);
    issue_op(fn, a, b);
    wait_latency(name);
    take_resp(name, stall, actual);
    if (fn == fn_mul || fn == fn_mulu) begin
      check_product(name, expected, actual);
    end else begin
      // nonzero signed remainder follows the dividend sign
      if (fn == fn_div && b != '0 && actual.qr.rem != '0) begin
        check_flag({name, " rem sign"}, a[31], actual.qr.rem[31]);
      end
      check_quo_rem(name, expected, actual);
    end
  endtask

  // ----------------------------
  // directed tests
  // ----------------------------
  task automatic test_reset_state();
    @(negedge clk);
    check_flag("reset req_rdy", 1'b1, req_rdy);
    check_flag("reset resp_val", 1'b0, resp_val);
  endtask

  task automatic test_mul_corners();
    for (int i = 0; i < 7; i++) begin
      for (int j = 0; j < 7; j++) begin
        run_op("mul", fn_mul, corner_value(i), corner_value(j), 0);
        run_op("mulu", fn_mulu, corner_value(i), corner_value(j), 0);
      end
    end
  endtask

  // divisor 0 is left to test_div_by_zero
  task automatic test_div_corners();
    for (int i = 0; i < 7; i++) begin
      for (int j = 1; j < 7; j++) begin
        run_op("div", fn_div, corner_value(i), corner_value(j), 0);
        run_op("divu", fn_divu, corner_value(i), corner_value(j), 0);
      end
    end
  endtask

  task automatic test_div_by_zero();
    for (int i = 0; i < 7; i++) begin
      run_op("div0", fn_div, corner_value(i), '0, 0);
      run_op("divu0", fn_divu, corner_value(i), '0, 0);
    end
  endtask

  task automatic test_back_pressure();
    logic [31:0] r;
    imuldiv_word_t a;
    imuldiv_word_t b;
    for (int k = 0; k < 8; k++) begin
      a = lcg_next();
      b = lcg_next();
      r = lcg_next();
      run_op("stall", imuldiv_fn_t'(k % 4), a, b, 1 + int'(r[31:16]) % max_stall);
    end
  endtask

  task automatic test_random_sweep();
    logic [31:0]   r;
    imuldiv_word_t a;
    imuldiv_word_t b;
    for (int k = 0; k < 200; k++) begin
      a = lcg_next();
      b = lcg_next();
      r = lcg_next();
      // shrink some divisors so quotients get wide
      b = b >> r[31:27];
      // upper LCG bits pick the code since the low ones are weak
      run_op("random", imuldiv_fn_t'(r[26:25]), a, b, int'(r[15:0]) % (max_stall + 1));
    end
  endtask

  // ----------------------------
  // main sequence and watchdog
  // ----------------------------
  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    req_val   = 1'b0;
    req_fn    = fn_mul;
    req_a     = '0;
    req_b     = '0;
    resp_rdy  = 1'b0;
    rng_state = 32'hf75f02ab;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    test_mul_corners();
    test_div_corners();
    test_div_by_zero();
    test_back_pressure();
    test_random_sweep();
    $display("Regression passed");
    $finish;
  end

  initial begin
    #(watchdog_ns);
    stop_with_error("timeout: the tests did not finish in the expected time");
  end

endmodule

`default_nettype wire

// ==== hw/imuldiv_top.sv ====
/*
  mul/div unit top level: decode, execute and result stages
*/
`timescale 1ns/1ps
`default_nettype none

module imuldiv_top
  import imuldiv_op_pkg::*;
  import imuldiv_data_pkg::*;
(
  input  wire             clk,
  input  wire             reset,
  input  wire             req_val,
  output logic            req_rdy,
  input  imuldiv_fn_t     req_fn,
  input  imuldiv_word_t   req_a,
  input  imuldiv_word_t   req_b,
  output logic            resp_val,
  input  wire             resp_rdy,
  output imuldiv_result_t resp_result
);

  // decode to execute/result
  logic            load;
  imuldiv_word_t   mag_a;
  imuldiv_word_t   mag_b;
  logic            is_div;
  logic            neg_hi;
  logic            neg_lo;
  logic            div_zero;
  imuldiv_word_t   dividend;
  // execute to result
  imuldiv_result_t raw;
  logic            done;

  imuldiv_decode decode_inst (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .req_fn   (req_fn),
    .req_a    (req_a),
    .req_b    (req_b),
    .mag_a    (mag_a),
    .mag_b    (mag_b),
    .is_div   (is_div),
    .neg_hi   (neg_hi),
    .neg_lo   (neg_lo),
    .div_zero (div_zero),
    .dividend (dividend)
  );

  imuldiv_execute execute_inst (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .load     (load),
    .resp_val (resp_val),
    .mag_a    (mag_a),
    .mag_b    (mag_b),
    .is_div   (is_div),
    .raw      (raw),
    .done     (done)
  );

  imuldiv_result result_inst (
    .clk         (clk),
    .reset       (reset),
    .done        (done),
    .raw         (raw),
    .is_div      (is_div),
    .neg_hi      (neg_hi),
    .neg_lo      (neg_lo),
    .div_zero    (div_zero),
    .dividend    (dividend),
    .resp_rdy    (resp_rdy),
    .resp_val    (resp_val),
    .resp_result (resp_result)
  );

endmodule

`default_nettype wire

// ==== hw/imuldiv_result.sv ====
/*
  result stage: sign fix-up, divide-by-zero override and the
  response register with its valid flag
*/
`timescale 1ns/1ps
`default_nettype none

module imuldiv_result
  import imuldiv_data_pkg::*;
(
  input  wire             clk,
  input  wire             reset,
  input  wire             done,
  input  imuldiv_result_t raw,
  input  wire             is_div,
  input  wire             neg_hi,
  input  wire             neg_lo,
  input  wire             div_zero,
  input  imuldiv_word_t   dividend,
  input  wire             resp_rdy,
  output logic            resp_val,
  output imuldiv_result_t resp_result
);

  imuldiv_result_t fixed;

  // ----------------------------
  // sign fix-up
  // ----------------------------
  always_comb begin
    fixed = raw;
    if (!is_div) begin
      // whole product negates as one word
      if (neg_lo) begin
        fixed.prod = ~raw.prod + 1'b1;
      end
    end else begin
      // quotient and remainder carry separate signs
      if (neg_lo) begin
        fixed.qr.quo = ~raw.qr.quo + 1'b1;
      end
      if (neg_hi) begin
        fixed.qr.rem = ~raw.qr.rem + 1'b1;
      end
      // x / 0 gives all ones and leaves x as remainder
      if (div_zero) begin
        fixed.qr.quo = '1;
        fixed.qr.rem = dividend;
      end
    end
  end

  // ----------------------------
  // response register
  // ----------------------------
  always_ff @(posedge clk) begin
    if (done) begin
      resp_result <= fixed;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (done) begin
      resp_val <= 1'b1;
    end else if (resp_val && resp_rdy) begin
      // consumer took it
      resp_val <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/imuldiv_decode.sv ====
/*
  request decode: operand magnitudes, sign fix-up flags,
  divide-by-zero flag and the saved dividend
*/
`timescale 1ns/1ps
`default_nettype none

module imuldiv_decode
  import imuldiv_op_pkg::*;
  import imuldiv_data_pkg::*;
(
  input  wire           clk,
  input  wire           reset,
  input  wire           load,
  input  imuldiv_fn_t   req_fn,
  input  imuldiv_word_t req_a,
  input  imuldiv_word_t req_b,
  output imuldiv_word_t mag_a,
  output imuldiv_word_t mag_b,
  output logic          is_div,
  output logic          neg_hi,
  output logic          neg_lo,
  output logic          div_zero,
  output imuldiv_word_t dividend
);

  // ----------------------------
  // operand signs
  // ----------------------------
  logic req_signed;
  logic req_div;
  logic sign_a;
  logic sign_b;

  assign req_signed = fn_is_signed(req_fn);
  assign req_div    = fn_is_div(req_fn);

  // unsigned codes never see a negative operand
  assign sign_a = req_signed & req_a[op_width-1];
  assign sign_b = req_signed & req_b[op_width-1];

  // ----------------------------
  // flags
  // ----------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      is_div   <= 1'b0;
      neg_hi   <= 1'b0;
      neg_lo   <= 1'b0;
      div_zero <= 1'b0;
    end else if (load) begin
      is_div <= req_div;
      // product sign or quotient sign
      neg_lo <= sign_a ^ sign_b;
      // remainder follows the dividend
      neg_hi   <= req_div ? sign_a : (sign_a ^ sign_b);
      div_zero <= req_div && (req_b == '0);
    end
  end

  // ----------------------------
  // operand words
  // ----------------------------
  always_ff @(posedge clk) begin
    if (load) begin
      mag_a    <= sign_a ? (~req_a + 1'b1) : req_a;
      mag_b    <= sign_b ? (~req_b + 1'b1) : req_b;
      dividend <= req_a;
    end
  end

endmodule

`default_nettype wire

// ==== execute/imuldiv_execute.sv ====
/*
  sequencing FSM and iteration counter driving the multiply and
  divide engines, with the handshake on the request side
*/
`timescale 1ns/1ps
`default_nettype none

module imuldiv_execute
  import imuldiv_data_pkg::*;
(
  input  wire             clk,
  input  wire             reset,
  input  wire             req_val,
  output logic            req_rdy,
  output logic            load,
  input  wire             resp_val,
  input  imuldiv_word_t   mag_a,
  input  imuldiv_word_t   mag_b,
  input  wire             is_div,
  output imuldiv_result_t raw,
  output logic            done
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_load = 2'd1;
  localparam logic [1:0] st_calc = 2'd2;

  logic [1:0]           state;
  logic [cnt_width-1:0] count;
  logic                 init;
  logic                 step;
  logic                 last;
  imuldiv_result_t      product;
  imuldiv_result_t      quo_rem;

  // ----------------------------
  // handshake and engine strobes
  // ----------------------------

  // done still high means the result stage has not caught the word yet
  assign req_rdy = (state == st_idle) && !done && !resp_val;
  assign load    = req_val && req_rdy;

  assign init = (state == st_load);
  assign step = (state == st_calc);
  assign last = step && (count == '0);

  // ----------------------------
  // state and counter
  // ----------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
      done  <= 1'b0;
    end else begin
      // done lands one cycle after the final step
      done <= last;
      case (state)
        st_idle: begin
          if (load) begin
            state <= st_load;
          end
        end
        st_load: begin
          state <= st_calc;
          count <= cnt_width'(iter_count - 1);
        end
        st_calc: begin
          count <= count - 1'b1;
          if (last) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ----------------------------
  // engines
  // ----------------------------
  imuldiv_mul_iter mul_iter_inst (
    .clk     (clk),
    .reset   (reset),
    .init    (init),
    .step    (step),
    .mag_a   (mag_a),
    .mag_b   (mag_b),
    .product (product)
  );

  imuldiv_div_iter div_iter_inst (
    .clk     (clk),
    .reset   (reset),
    .init    (init),
    .step    (step),
    .mag_a   (mag_a),
    .mag_b   (mag_b),
    .quo_rem (quo_rem)
  );

  // both engines ran so pick the one the request asked for
  assign raw = is_div ? quo_rem : product;

endmodule

`default_nettype wire

// ==== execute/imuldiv_div_iter.sv ====
/*
  restoring shift-subtract divider on operand magnitudes,
  one quotient bit per step
*/
`timescale 1ns/1ps
`default_nettype none

module imuldiv_div_iter
  import imuldiv_data_pkg::*;
(
  input  wire             clk,
  input  wire             reset,
  input  wire             init,
  input  wire             step,
  input  imuldiv_word_t   mag_a,
  input  imuldiv_word_t   mag_b,
  output imuldiv_result_t quo_rem
);

  imuldiv_word_t   divisor;
  imuldiv_result_t rq;

  // register shifted left with the top bit kept so the partial
  // remainder never loses its carry-out
  logic [2*op_width:0]   shifted;
  logic [op_width+1:0]   diff;
  logic                  borrow;

  assign shifted = {rq.prod, 1'b0};

  // trial subtract against the upper part
  assign diff   = {1'b0, shifted[2*op_width:op_width]} - {2'b00, divisor};
  assign borrow = diff[op_width+1];

  // ----------------------------
  // divisor
  // ----------------------------
  always_ff @(posedge clk) begin
    if (init) begin
      divisor <= mag_b;
    end
  end

  // ----------------------------
  // remainder/quotient register
  // ----------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      rq.prod <= '0;
    end else if (init) begin
      rq.qr.rem <= '0;
      rq.qr.quo <= mag_a;
    end else if (step) begin
      if (borrow) begin
        // restore and leave the quotient bit at zero
        rq.prod <= shifted[2*op_width-1:0];
      end else begin
        rq.qr.rem <= diff[op_width-1:0];
        rq.qr.quo <= {shifted[op_width-1:1], 1'b1};
      end
    end
  end

  assign quo_rem = rq;

endmodule

`default_nettype wire

// ==== execute/imuldiv_mul_iter.sv ====
/*
  shift-add multiplier on operand magnitudes, one multiplier bit
  per step
*/
`timescale 1ns/1ps
`default_nettype none

module imuldiv_mul_iter
  import imuldiv_data_pkg::*;
(
  input  wire             clk,
  input  wire             reset,
  input  wire             init,
  input  wire             step,
  input  imuldiv_word_t   mag_a,
  input  imuldiv_word_t   mag_b,
  output imuldiv_result_t product
);

  // multiplicand walks left across the full product width
  logic [2*op_width-1:0] mcand;
  imuldiv_word_t         mplier;
  imuldiv_result_t       acc;

  // ----------------------------
  // shifting operands
  // ----------------------------
  always_ff @(posedge clk) begin
    if (init) begin
      mcand  <= {{op_width{1'b0}}, mag_a};
      mplier <= mag_b;
    end else if (step) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // ----------------------------
  // accumulator
  // ----------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      acc.prod <= '0;
    end else if (init) begin
      acc.prod <= '0;
    end else if (step && mplier[0]) begin
      // add the current multiplicand weight
      acc.prod <= acc.prod + mcand;
    end
  end

  assign product = acc;

endmodule

`default_nettype wire

// ==== common/imuldiv_data_pkg.sv ====
/*
  operand and result widths, the operand word type and the
  64-bit result word with its product and quotient/remainder views
*/
`default_nettype none

package imuldiv_data_pkg;

  // operand width in bits
  localparam int op_width = 32;

  // one result bit per iteration
  localparam int iter_count = 32;
  localparam int cnt_width  = $clog2(iter_count);

  typedef logic [op_width-1:0] imuldiv_word_t;

  // quotient/remainder view with the remainder in the upper half
  typedef struct packed {
    imuldiv_word_t rem;
    imuldiv_word_t quo;
  } imuldiv_qr_t;

  // multiply writes prod and divide writes qr
  typedef union packed {
    logic [2*op_width-1:0] prod;
    imuldiv_qr_t           qr;
  } imuldiv_result_t;

endpackage

`default_nettype wire

// ==== common/imuldiv_op_pkg.sv ====
/*
  request function codes of the mul/div unit and the helpers that
  decode a code into signedness and engine selection
*/
`default_nettype none

package imuldiv_op_pkg;

  // request function code as carried on req_fn
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_mulu = 2'd1,
    fn_div  = 2'd2,
    fn_divu = 2'd3
  } imuldiv_fn_t;

  // true for the two divide codes
  function automatic logic fn_is_div(imuldiv_fn_t fn);
    return (fn == fn_div) || (fn == fn_divu);
  endfunction

  // true when the operands are taken as two's complement
  function automatic logic fn_is_signed(imuldiv_fn_t fn);
    return (fn == fn_mul) || (fn == fn_div);
  endfunction

endpackage

`default_nettype wire
